/* scatter_defines.svh */
`ifndef SCATTER_DEFINES_SVH
`define SCATTER_DEFINES_SVH

// ############################
// Scatter unit geometry
// ############################

// Outputs of one demux tree
`define SCATTER_LANES 128

// Lane address width, log2 of the lane count
`define SCATTER_ADDR_W 7

// Independent trees
`define SCATTER_BANKS 2

// Command word on the input port
`define SCATTER_CMD_W 16

`endif

/* scatter_cmd_pkg.sv */
`include "scatter_defines.svh"

package scatter_cmd_pkg;

    // ############################
    // Command opcodes
    // ############################

    typedef enum logic [1:0]
    {
        OP_NOP   = 2'd0,
        OP_WRITE = 2'd1,
        OP_VIEW  = 2'd2                                    // 2'd3 unused, ignored
    } scatter_opcode_e;

    // ############################
    // Command formats
    // ############################

    typedef struct packed
    {
        scatter_opcode_e                                       opcode;
        logic                                                  bank;
        logic [`SCATTER_CMD_W-`SCATTER_ADDR_W-5:0]             reserved;
        logic [`SCATTER_ADDR_W-1:0]                            addr;
        logic                                                  data;
    } scatter_write_t;

    typedef struct packed
    {
        scatter_opcode_e                  opcode;            // Same bits as in write
        logic                             view_bank;
        logic [`SCATTER_CMD_W-4:0]        reserved;
    } scatter_view_t;

    // One command word, two readings
    typedef union packed
    {
        scatter_write_t write;
        scatter_view_t  view;
    } scatter_cmd_u;

endpackage

/* scatter_port_pkg.sv */
`include "scatter_defines.svh"

package scatter_port_pkg;

    // ############################
    // Decoder to steering
    // ############################

    typedef struct packed
    {
        logic                          valid;
        logic                          bank;              // Target tree
        logic [`SCATTER_ADDR_W-1:0]    addr;              // Target lane
        logic                          data;
    } scatter_route_t;

    // ############################
    // Output port
    // ############################

    typedef struct packed
    {
        logic                          valid;             // One-cycle pulse
        logic [`SCATTER_LANES-1:0]     lanes;
    } scatter_out_t;

endpackage

/* scatter_cmd_decoder.sv */
`timescale 1ns/1ps

module scatter_cmd_decoder
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cmd_strobe,
    input  scatter_cmd_pkg::scatter_cmd_u   cmd,
    output scatter_port_pkg::scatter_route_t route,
    output logic                            view_bank
);

    import scatter_cmd_pkg::*;
    import scatter_port_pkg::*;

    logic                          is_write;
    logic                          is_view;
    logic                          valid_q;
    logic                          bank_q;
    logic [$bits(route.addr)-1:0]  addr_q;
    logic                          data_q;
    logic                          view_bank_q;

    // ############################
    // Opcode decode
    // ############################

    // Both formats share the opcode position
    assign is_write = cmd_strobe && (cmd.write.opcode == OP_WRITE);
    assign is_view  = cmd_strobe && (cmd.view.opcode == OP_VIEW);

    // ############################
    // Command registers
    // ############################

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q     <= 1'b0;
            view_bank_q <= 1'b0;
        end
        else
        begin
            valid_q <= is_write;                            // Single-cycle request
            if (is_view)
            begin
                view_bank_q <= cmd.view.view_bank;
            end
        end
    end

    // Write payload, qualified by valid_q
    always_ff @(posedge clk)
    begin
        if (is_write)
        begin
            bank_q <= cmd.write.bank;
            addr_q <= cmd.write.addr;
            data_q <= cmd.write.data;
        end
    end

    assign route = '{valid: valid_q, bank: bank_q, addr: addr_q, data: data_q};
    assign view_bank = view_bank_q;

endmodule

/* demux_tree.sv */
`timescale 1ns/1ps

`include "scatter_defines.svh"

module demux_tree
#(
    parameter int ADDR_W = `SCATTER_ADDR_W
)
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     data,
    input  logic [ADDR_W-1:0]        sel,
    output logic [2**ADDR_W-1:0]     lanes
);

    localparam int HALF = 2**(ADDR_W-1);

    generate
        if (ADDR_W > 1)
        begin : g_split
            logic data_lo;
            logic data_hi;

            // ############################
            // Combinational 1-to-2 split
            // ############################

            assign data_lo = sel[ADDR_W-1] ? 1'b0 : data;
            assign data_hi = sel[ADDR_W-1] ? data : 1'b0;

            demux_tree
            #(
                .ADDR_W (ADDR_W-1)
            )
            lo_tree
            (
                .clk    (clk),
                .rst_n  (rst_n),
                .data   (data_lo),
                .sel    (sel[ADDR_W-2:0]),
                .lanes  (lanes[HALF-1:0])                  // Lower half for sel MSB 0
            );

            demux_tree
            #(
                .ADDR_W (ADDR_W-1)
            )
            hi_tree
            (
                .clk    (clk),
                .rst_n  (rst_n),
                .data   (data_hi),
                .sel    (sel[ADDR_W-2:0]),
                .lanes  (lanes[2*HALF-1:HALF])
            );
        end
        else
        begin : g_leaf
            // ############################
            // Registered last split
            // ############################

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    lanes <= '0;
                end
                else
                begin
                    lanes[0] <= data & ~sel[0];
                    lanes[1] <= data & sel[0];
                end
            end
        end
    endgenerate

endmodule

/* demux_bank_steer.sv */
`timescale 1ns/1ps

`include "scatter_defines.svh"

module demux_bank_steer
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  scatter_port_pkg::scatter_route_t route,
    input  logic                             view_bank,
    output scatter_port_pkg::scatter_out_t   lanes_out
);

    import scatter_port_pkg::*;

    logic                         bank0_data;
    logic                         bank1_data;
    logic [`SCATTER_LANES-1:0]    tree_lanes [`SCATTER_BANKS];
    logic                         valid_q;
    logic                         bank_q;

    // ############################
    // Input steering
    // ############################

    // Idle tree sees a constant zero
    assign bank0_data = route.valid & route.data & ~route.bank;
    assign bank1_data = route.valid & route.data & route.bank;

    demux_tree
    #(
        .ADDR_W (`SCATTER_ADDR_W)
    )
    bank0_tree
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .data   (bank0_data),
        .sel    (route.addr),
        .lanes  (tree_lanes[0])
    );

    demux_tree
    #(
        .ADDR_W (`SCATTER_ADDR_W)
    )
    bank1_tree
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .data   (bank1_data),
        .sel    (route.addr),
        .lanes  (tree_lanes[1])
    );

    // ############################
    // Valid pipeline
    // ############################

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
            bank_q  <= 1'b0;
        end
        else
        begin
            valid_q <= route.valid;                         // Matches leaf register stage
            bank_q  <= route.bank;
        end
    end

    // ############################
    // Output multiplexing
    // ############################

    assign lanes_out.valid = valid_q && (bank_q == view_bank);
    assign lanes_out.lanes = tree_lanes[view_bank];

endmodule

/* bit_scatter_top.sv */
`timescale 1ns/1ps

module bit_scatter_top
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_strobe,
    input  scatter_cmd_pkg::scatter_cmd_u  cmd,
    output scatter_port_pkg::scatter_out_t lanes_out
);

    import scatter_port_pkg::*;

    scatter_route_t route;                                  // Decoded write request
    logic           view_bank;

    // ############################
    // Command decode
    // ############################

    scatter_cmd_decoder u_decoder
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .route      (route),
        .view_bank  (view_bank)
    );

    // ############################
    // Bank trees and output mux
    // ############################

    demux_bank_steer u_steer
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .route      (route),
        .view_bank  (view_bank),
        .lanes_out  (lanes_out)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter real PERIOD_NS    = 40.0,
    parameter int  RESET_CYCLES = 16
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                                     // Release away from the active edge
        rst_n = 1'b1;
    end

endmodule

/* tb_bit_scatter.sv */
`timescale 1ns/1ps

`include "scatter_defines.svh"

module tb_bit_scatter;

    import scatter_cmd_pkg::*;
    import scatter_port_pkg::*;

    localparam int          MAX_GAP   = 3;
    localparam logic [31:0] LFSR_SEED = 32'h1ac4b89e;
    localparam logic [31:0] LFSR_TAPS = 32'hA3000000;       // x^32 + x^30 + x^26 + x^25 + 1

    typedef struct packed
    {
        logic [1:0]                   opcode;
        logic                         bank;                 // View bank for a view entry
        logic [`SCATTER_ADDR_W-1:0]   addr;
        logic                         data;
        logic [1:0]                   gap;                  // Idle cycles after the strobe
    } stim_t;

    logic           clk;
    logic           rst_n;
    logic           cmd_strobe;
    scatter_cmd_u   cmd;
    scatter_out_t   lanes_out;

    stim_t          stim_table [$];
    scatter_route_t pending [$];                            // Writes in flight, oldest first
    logic           model_view;
    logic [31:0]    lfsr_state;
    int             cycle_count = 0;
    int             cycle_limit;

    tb_clock_gen
    #(
        .PERIOD_NS    (40.0),
        .RESET_CYCLES (16)
    )
    u_clock_gen
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bit_scatter_top UUT
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .lanes_out  (lanes_out)
    );

    // ############################
    // Helpers
    // ############################

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_entry(input logic [1:0] opcode, input logic bank,
                             input logic [`SCATTER_ADDR_W-1:0] addr, input logic data,
                             input logic [1:0] gap);
        stim_t e;
        e.opcode = opcode;
        e.bank   = bank;
        e.addr   = addr;
        e.data   = data;
        e.gap    = gap;
        stim_table.push_back(e);
    endtask

    // ############################
    // Stimulus table
    // ############################

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] rnd_addr;
        for (int a = 0; a < `SCATTER_LANES; a++)
        begin
            add_entry(OP_WRITE, 1'b0, a[`SCATTER_ADDR_W-1:0], 1'b1, 2'(a % 3));
        end
        for (int i = 0; i < 8; i++)
        begin
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            add_entry(OP_WRITE, 1'b0, rnd_addr[`SCATTER_ADDR_W-1:0], 1'b0, 2'd1);
        end
        for (int i = 0; i < 8; i++)                         // Hidden behind view 0
        begin
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            add_entry(OP_WRITE, 1'b1, rnd_addr[`SCATTER_ADDR_W-1:0], 1'b1, 2'd0);
        end
        add_entry(OP_VIEW, 1'b1, '0, 1'b0, 2'd0);
        for (int i = 0; i < 16; i++)
        begin
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            take_bits(2, rnd);
            add_entry(OP_WRITE, 1'b1, rnd_addr[`SCATTER_ADDR_W-1:0], 1'b1, rnd[1:0]);
        end
        for (int i = 0; i < 4; i++)
        begin
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            add_entry(OP_WRITE, 1'b0, rnd_addr[`SCATTER_ADDR_W-1:0], 1'b1, 2'd0);
        end
        // NOP and unused opcode on the viewed bank first, then on the other one
        for (int i = 0; i < 8; i++)
        begin
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            add_entry(i[0] ? 2'd3 : 2'd0, ~i[2], rnd_addr[`SCATTER_ADDR_W-1:0], 1'b1, 2'd0);
        end
        for (int i = 0; i < 4; i++)
        begin
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            add_entry(OP_WRITE, 1'b1, rnd_addr[`SCATTER_ADDR_W-1:0], 1'b1, 2'd0);
        end
        add_entry(OP_VIEW, 1'b0, '0, 1'b0, 2'd0);
        for (int i = 0; i < 64; i++)                        // Back to back
        begin
            take_bits(3, rnd);
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            if (i == 32)
            begin
                add_entry(OP_VIEW, 1'b1, '0, 1'b0, 2'd0);
            end
            add_entry(OP_WRITE, rnd[0], rnd_addr[`SCATTER_ADDR_W-1:0], rnd[1], 2'd0);
        end
        add_entry(OP_VIEW, 1'b0, '0, 1'b0, 2'd0);
        for (int i = 0; i < 8; i++)                         // Same mix under view 0
        begin
            add_entry(i[0] ? 2'd3 : 2'd0, i[2], 7'd5, 1'b1, 2'd1);
        end
        for (int i = 0; i < 4; i++)
        begin
            take_bits(`SCATTER_ADDR_W, rnd_addr);
            add_entry(OP_WRITE, 1'b0, rnd_addr[`SCATTER_ADDR_W-1:0], 1'b1, 2'd0);
        end
    endtask

    // ############################
    // Checks and model
    // ############################

    task automatic check_outputs(input scatter_route_t oldest);
        logic                        exp_valid;
        logic [`SCATTER_LANES-1:0]   exp_lanes;
        exp_valid = oldest.valid && (oldest.bank == model_view);
        exp_lanes = '0;
        if (exp_valid)
        begin
            exp_lanes[oldest.addr] = oldest.data;
        end
        assert (lanes_out.valid === exp_valid)
        else
        begin
            $display("[FAIL] time %0t lanes_out.valid expected %0b actual %0b",
                     $time, exp_valid, lanes_out.valid);
            stop_run();
        end
        assert (lanes_out.lanes === exp_lanes)
        else
        begin
            $display("[FAIL] time %0t lanes_out.lanes expected %h actual %h",
                     $time, exp_lanes, lanes_out.lanes);
            stop_run();
        end
    endtask

    // Check what the last edge produced, then drive the next cycle
    task automatic run_cycle(input logic strobe, input stim_t e, input scatter_cmd_u word);
        scatter_route_t oldest;
        scatter_route_t entry;
        @(negedge clk);
        oldest = pending.pop_front();
        check_outputs(oldest);
        cmd_strobe = strobe;
        cmd        = word;
        entry      = '0;
        if (strobe && e.opcode == OP_WRITE)
        begin
            entry.valid = 1'b1;
            entry.bank  = e.bank;
            entry.addr  = e.addr;
            entry.data  = e.data;
        end
        if (strobe && e.opcode == OP_VIEW)
        begin
            model_view = e.bank;                            // Visible from the next edge
        end
        pending.push_back(entry);
    endtask

    task automatic apply_entry(input stim_t e);
        scatter_cmd_u word;
        word = '0;
        if (e.opcode == OP_VIEW)
        begin
            word.view.opcode    = OP_VIEW;
            word.view.view_bank = e.bank;
        end
        else
        begin
            word.write.opcode = scatter_opcode_e'(e.opcode);
            word.write.bank   = e.bank;
            word.write.addr   = e.addr;
            word.write.data   = e.data;
        end
        run_cycle(1'b1, e, word);
        for (int g = 0; g < int'(e.gap); g++)
        begin
            run_cycle(1'b0, e, word);                       // Word held with strobe low
        end
    endtask

    task automatic idle_cycles(input int count);
        stim_t idle;
        idle = '0;
        for (int i = 0; i < count; i++)
        begin
            run_cycle(1'b0, idle, '0);
        end
    endtask

    // ############################
    // Main sequence
    // ############################

    initial
    begin
        cmd_strobe = 1'b0;
        cmd        = '0;
        model_view = 1'b0;
        lfsr_state = LFSR_SEED;
        build_table();
        cycle_limit = stim_table.size() * (MAX_GAP + 4) + 100;
        pending.push_back('0);
        pending.push_back('0);
        @(posedge rst_n);
        idle_cycles(4);                                     // Quiet after reset
        for (int i = 0; i < stim_table.size(); i++)
        begin
            apply_entry(stim_table[i]);
        end
        idle_cycles(4);                                     // Drain the pipeline
        $display("TEST OK");
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles before the command table finished",
                     cycle_count);
            stop_run();
        end
    end

endmodule

/* build.f */
+incdir+.
scatter_cmd_pkg.sv
scatter_port_pkg.sv
scatter_cmd_decoder.sv
demux_tree.sv
demux_bank_steer.sv
bit_scatter_top.sv
tb_clock_gen.sv
tb_bit_scatter.sv

/* Makefile */
# Verilator build and run for the bit-scatter unit

TOP := tb_bit_scatter

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee run.log
	@if grep -q "TEST FAILED" run.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" run.log; then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log
